//--- decode_stage.f
common/decode_pkg.sv
common/dispatch_if.sv
decoder/decoder_3r.sv
decoder/decoder_2ri12.sv
decoder/decoder_i26.sv
decoder/decoder_priv.sv
decoder/id.sv
verilog/instr_latch.sv
verilog/dispatch_reg.sv
verilog/decode_stage.sv
sim/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_stage \
    -f decode_stage.f -o sim_decode_stage > build.log 2>&1 \
    && ./obj_dir/sim_decode_stage > sim.log 2>&1 \
    || { echo "Build or run of the simulation failed, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION FAILED" sim.log \
    && { echo "Testbench reported errors, see sim.log"; exit 1; } \
    || { echo "Testbench reported no errors"; exit 0; }

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam int N_LEGAL = 200;
    localparam int N_RAW   = 60;
    localparam int N_MIX   = 40;
    localparam int N_STALL = 60;
    localparam int DRAIN   = 3;
    // Reset, legal, raw plus break and syscall, priv, mix, stall and flush
    localparam int STIM_CYCLES = 2 + N_LEGAL + N_RAW + 2 + 6 + N_MIX + N_STALL + 5 * DRAIN;
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

    typedef struct packed {
        logic              valid;
        logic [31:0]       pc;
        logic [31:0]       instr;
        aluop_e            aluop;
        alusel_e           alusel;
        logic [1:0]        rd_valid;
        logic [1:0][4:0]   rd_addr;
        logic              wr_valid;
        logic [4:0]        wr_addr;
        logic [31:0]       imm;
        logic              use_imm;
        logic              refetch;
        logic [EXCP_W-1:0] excp_num;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              stall;
    logic              flush;
    logic              instr_valid;
    logic [31:0]       pc;
    logic [31:0]       instr;
    logic              adef;
    logic              has_int;
    logic [1:0]        csr_plv;
    logic              disp_valid;
    logic [31:0]       disp_pc;
    logic [31:0]       disp_instr;
    aluop_e            disp_aluop;
    alusel_e           disp_alusel;
    logic [1:0]        disp_rd_valid;
    logic [1:0][4:0]   disp_rd_addr;
    logic              disp_wr_valid;
    logic [4:0]        disp_wr_addr;
    logic [31:0]       disp_imm;
    logic              disp_use_imm;
    logic              disp_refetch;
    logic              disp_excp;
    logic [EXCP_W-1:0] disp_excp_num;

    instr_info_t pend_info;
    expect_t     exp_head;
    int          err_cnt   = 0;
    int          err_mark  = 0;
    int          test_cnt  = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;

    decode_stage i_dut (
        .clk                    (clk),
        .rst_n_i                (rst_n),
        .stall_i                (stall),
        .flush_i                (flush),
        .instr_valid_i          (instr_valid),
        .pc_i                   (pc),
        .instr_i                (instr),
        .adef_i                 (adef),
        .has_int_i              (has_int),
        .csr_plv_i              (csr_plv),
        .disp_valid_o           (disp_valid),
        .disp_pc_o              (disp_pc),
        .disp_instr_o           (disp_instr),
        .disp_aluop_o           (disp_aluop),
        .disp_alusel_o          (disp_alusel),
        .disp_reg_read_valid_o  (disp_rd_valid),
        .disp_reg_read_addr_o   (disp_rd_addr),
        .disp_reg_write_valid_o (disp_wr_valid),
        .disp_reg_write_addr_o  (disp_wr_addr),
        .disp_imm_o             (disp_imm),
        .disp_use_imm_o         (disp_use_imm),
        .disp_refetch_o         (disp_refetch),
        .disp_excp_o            (disp_excp),
        .disp_excp_num_o        (disp_excp_num)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic expect_t ref_decode(input instr_info_t info, input logic intr,
                                           input logic [1:0] plv);
        expect_t     e;
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        w       = info.instr;
        rd      = w[4:0];
        rj      = w[9:5];
        rk      = w[14:10];
        e       = '0;
        e.valid = info.valid;
        e.pc    = info.pc;
        e.instr = w;
        if (!info.valid) begin
            return e;
        end
        case (w[31:15])
            17'h00020: e.aluop = ADD;
            17'h00022: e.aluop = SUB;
            17'h00024: e.aluop = SLT;
            17'h00029: e.aluop = AND;
            17'h0002a: e.aluop = OR;
            17'h0002b: e.aluop = XOR;
            17'h00054: e.aluop = BREAK;
            17'h00056: e.aluop = SYSCALL;
            default: ;
        endcase
        case (w[31:22])
            10'h008: e.aluop = SLTI;
            10'h00a: e.aluop = ADDI;
            10'h00d: e.aluop = ANDI;
            10'h00e: e.aluop = ORI;
            10'h0a2: e.aluop = LD_W;
            10'h0a6: e.aluop = ST_W;
            default: ;
        endcase
        case (w[31:26])
            6'h14:   e.aluop = B;
            6'h15:   e.aluop = BL;
            default: ;
        endcase
        if (w[31:24] == 8'h04 && rj == 5'd0) begin
            e.aluop = CSRRD;
        end
        if (w[31:24] == 8'h04 && rj == 5'd1) begin
            e.aluop = CSRWR;
        end
        if (w == 32'h0648_3800) begin
            e.aluop = ERTN;
        end
        case (e.aluop)
            ADD, SUB, SLT, AND, OR, XOR: begin
                e.alusel     = (e.aluop inside {AND, OR, XOR}) ? LOGIC : ARITH;
                e.rd_valid   = 2'b11;
                e.rd_addr[0] = rj;
                e.rd_addr[1] = rk;
                e.wr_valid   = 1'b1;
                e.wr_addr    = rd;
            end
            SLTI, ADDI, ANDI, ORI, LD_W, ST_W: begin
                e.use_imm     = 1'b1;
                e.rd_valid[0] = 1'b1;
                e.rd_addr[0]  = rj;
                if (e.aluop inside {ANDI, ORI}) begin
                    e.alusel = LOGIC;
                    e.imm    = {20'b0, w[21:10]};
                end else begin
                    e.alusel = (e.aluop inside {LD_W, ST_W}) ? MEM : ARITH;
                    e.imm    = {{20{w[21]}}, w[21:10]};
                end
                if (e.aluop == ST_W) begin
                    e.rd_valid[1] = 1'b1;
                    e.rd_addr[1]  = rd;
                end else begin
                    e.wr_valid = 1'b1;
                    e.wr_addr  = rd;
                end
            end
            B, BL: begin
                e.alusel   = BRANCH;
                e.imm      = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
                e.wr_valid = (e.aluop == BL);
                e.wr_addr  = (e.aluop == BL) ? REG_RA : 5'd0;
            end
            CSRRD, CSRWR: begin
                e.alusel      = CSR;
                e.imm         = {18'b0, w[23:10]};
                e.wr_valid    = 1'b1;
                e.wr_addr     = rd;
                e.rd_valid[0] = (e.aluop == CSRWR);
                e.rd_addr[0]  = (e.aluop == CSRWR) ? rd : 5'd0;
            end
            ERTN: begin
                e.alusel  = CSR;
                e.refetch = 1'b1;
            end
            default: ;
        endcase
        e.excp_num = {(e.aluop inside {CSRRD, CSRWR, ERTN}) && plv == PLV_USER,
                      e.aluop == NOP, e.aluop == BREAK, e.aluop == SYSCALL, info.adef, intr};
        return e;
    endfunction

    // One random encoding from each legal rule, selected by sel
    function automatic logic [31:0] legal_word(input logic [4:0] sel, input logic [31:0] r);
        case (sel)
            5'd0:    return {17'h00020, r[14:0]};
            5'd1:    return {17'h00022, r[14:0]};
            5'd2:    return {17'h00024, r[14:0]};
            5'd3:    return {17'h00029, r[14:0]};
            5'd4:    return {17'h0002a, r[14:0]};
            5'd5:    return {17'h0002b, r[14:0]};
            5'd6:    return {17'h00054, r[14:0]};
            5'd7:    return {17'h00056, r[14:0]};
            5'd8:    return {10'h008, r[21:0]};
            5'd9:    return {10'h00a, r[21:0]};
            5'd10:   return {10'h00d, r[21:0]};
            5'd11:   return {10'h00e, r[21:0]};
            5'd12:   return {10'h0a2, r[21:0]};
            5'd13:   return {10'h0a6, r[21:0]};
            5'd14:   return {6'h14, r[25:0]};
            5'd15:   return {6'h15, r[25:0]};
            5'd16:   return {8'h04, r[23:10], 4'b0000, r[25], r[4:0]};
            default: return 32'h0648_3800;
        endcase
    endfunction

    // Two-deep expected pipeline, one slot per DUT register
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_info.valid <= 1'b0;
            exp_head.valid  <= 1'b0;
        end else if (flush) begin
            pend_info.valid <= 1'b0;
            exp_head.valid  <= 1'b0;
        end else if (!stall) begin
            pend_info <= '{instr_valid, pc, instr, adef};
            exp_head  <= ref_decode(pend_info, has_int, csr_plv);
        end
    end

    always @(posedge clk) begin
        if (rst_n && exp_head.valid) begin
            check_cnt <= check_cnt + 1;
        end
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped: tests still running after %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        err_cnt = err_cnt + 1;
    endtask

    a_reset_low: assert property (@(posedge clk)
        (!rst_n && $past(rst_n) == 1'b0) |-> (!disp_valid && !disp_excp))
        else report_mismatch("valid or excp high during reset");

    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        disp_valid == exp_head.valid)
        else report_mismatch("disp_valid differs from expected");

    a_excp: assert property (@(posedge clk) disable iff (!rst_n)
        disp_excp == (exp_head.valid && |exp_head.excp_num))
        else report_mismatch("disp_excp differs from expected");

    a_excp_num: assert property (@(posedge clk) disable iff (!rst_n)
        exp_head.valid |-> disp_excp_num == exp_head.excp_num)
        else report_mismatch($sformatf("excp_num for instr %h", $sampled(exp_head.instr)));

    a_op: assert property (@(posedge clk) disable iff (!rst_n)
        exp_head.valid |-> (disp_aluop == exp_head.aluop && disp_alusel == exp_head.alusel))
        else report_mismatch($sformatf("aluop or alusel for instr %h",
                                       $sampled(exp_head.instr)));

    a_regs: assert property (@(posedge clk) disable iff (!rst_n)
        exp_head.valid |-> (disp_rd_valid == exp_head.rd_valid
            && disp_rd_addr == exp_head.rd_addr && disp_wr_valid == exp_head.wr_valid
            && disp_wr_addr == exp_head.wr_addr))
        else report_mismatch($sformatf("register fields for instr %h",
                                       $sampled(exp_head.instr)));

    a_imm: assert property (@(posedge clk) disable iff (!rst_n)
        exp_head.valid |-> (disp_imm == exp_head.imm && disp_use_imm == exp_head.use_imm))
        else report_mismatch($sformatf("immediate for instr %h", $sampled(exp_head.instr)));

    a_pass_through: assert property (@(posedge clk) disable iff (!rst_n)
        exp_head.valid |-> (disp_pc == exp_head.pc && disp_instr == exp_head.instr
            && disp_refetch == exp_head.refetch))
        else report_mismatch("pc, instr or refetch differs from expected");

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> ($stable(disp_valid) && $stable(disp_pc)
            && $stable(disp_aluop) && $stable(disp_excp_num)))
        else report_mismatch("outputs moved while stalled");

    task automatic drive(input logic v, input logic [31:0] w, input logic af,
                         input logic intr, input logic [1:0] plv, input logic stl,
                         input logic fl);
        @(posedge clk);
        #1;
        instr_valid = v;
        instr       = w;
        pc          = pc + 32'd4;
        adef        = af;
        has_int     = intr;
        csr_plv     = plv;
        stall       = stl;
        flush       = fl;
    endtask

    task automatic drain();
        repeat (DRAIN) drive(1'b0, 32'h0, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0);
    endtask

    task automatic end_test(input string name);
        test_cnt = test_cnt + 1;
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    initial begin
        logic [31:0] r;
        logic [1:0]  level;
        void'($urandom(88));
        rst_n       = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        instr_valid = 1'b0;
        pc          = 32'h1c00_0000;
        instr       = 32'h0;
        adef        = 1'b0;
        has_int     = 1'b0;
        csr_plv     = 2'd0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        end_test("reset");

        for (int i = 0; i < N_LEGAL; i++) begin
            drive(1'b1, legal_word(5'($urandom_range(17, 0)), $urandom),
                  1'b0, 1'b0, 2'd0, 1'b0, 1'b0);
        end
        drain();
        end_test("legal formats");

        for (int i = 0; i < N_RAW; i++) begin
            drive(1'b1, $urandom, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0);
        end
        drive(1'b1, 32'h002a_0000, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0);
        drive(1'b1, 32'h002b_0000, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0);
        drain();
        end_test("illegal, break, syscall");

        // Kernel level first, then user level
        for (int p = 0; p < 2; p++) begin
            level = (p == 0) ? 2'd0 : PLV_USER;
            r     = $urandom;
            drive(1'b1, {8'h04, r[23:10], 5'd0, r[4:0]}, 1'b0, 1'b0, level, 1'b0, 1'b0);
            drive(1'b1, {8'h04, r[23:10], 5'd1, r[4:0]}, 1'b0, 1'b0, level, 1'b0, 1'b0);
            drive(1'b1, 32'h0648_3800, 1'b0, 1'b0, level, 1'b0, 1'b0);
        end
        drain();
        end_test("privilege");

        for (int i = 0; i < N_MIX; i++) begin
            r = $urandom;
            drive(r[31], legal_word(5'($urandom_range(17, 0)), $urandom),
                  r[30], r[29], r[28:27], 1'b0, 1'b0);
        end
        drain();
        end_test("int and adef");

        // Stall runs of three, flush every 13th cycle, some of them during a stall
        for (int i = 0; i < N_STALL; i++) begin
            drive(1'b1, legal_word(5'($urandom_range(17, 0)), $urandom), 1'b0, 1'b0, 2'd0,
                  (i % 7) inside {2, 3, 4}, (i % 13) == 12);
        end
        drain();
        end_test("stall and flush");

        $display("%0d tests, %0d instructions checked, %0d errors",
                 test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          instr_valid_i,
    input  logic [31:0]                   pc_i,
    input  logic [31:0]                   instr_i,
    input  logic                          adef_i,
    input  logic                          has_int_i,
    input  logic [1:0]                    csr_plv_i,
    output logic                          disp_valid_o,
    output logic [31:0]                   disp_pc_o,
    output logic [31:0]                   disp_instr_o,
    output decode_pkg::aluop_e            disp_aluop_o,
    output decode_pkg::alusel_e           disp_alusel_o,
    output logic [1:0]                    disp_reg_read_valid_o,
    output logic [1:0][4:0]               disp_reg_read_addr_o,
    output logic                          disp_reg_write_valid_o,
    output logic [4:0]                    disp_reg_write_addr_o,
    output logic [31:0]                   disp_imm_o,
    output logic                          disp_use_imm_o,
    output logic                          disp_refetch_o,
    output logic                          disp_excp_o,
    output logic [decode_pkg::EXCP_W-1:0] disp_excp_num_o
);
    import decode_pkg::*;

    instr_info_t instr_info;

    dispatch_if disp_if ();

    instr_latch u_instr_latch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .adef_i        (adef_i),
        .instr_info_o  (instr_info)
    );

    id u_id (
        .instr_info_i (instr_info),
        .has_int_i    (has_int_i),
        .csr_plv_i    (csr_plv_i),
        .disp         (disp_if.id_mp)
    );

    dispatch_reg u_dispatch_reg (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .stall_i                (stall_i),
        .flush_i                (flush_i),
        .disp                   (disp_if.disp_mp),
        .disp_valid_o           (disp_valid_o),
        .disp_pc_o              (disp_pc_o),
        .disp_instr_o           (disp_instr_o),
        .disp_aluop_o           (disp_aluop_o),
        .disp_alusel_o          (disp_alusel_o),
        .disp_reg_read_valid_o  (disp_reg_read_valid_o),
        .disp_reg_read_addr_o   (disp_reg_read_addr_o),
        .disp_reg_write_valid_o (disp_reg_write_valid_o),
        .disp_reg_write_addr_o  (disp_reg_write_addr_o),
        .disp_imm_o             (disp_imm_o),
        .disp_use_imm_o         (disp_use_imm_o),
        .disp_refetch_o         (disp_refetch_o),
        .disp_excp_o            (disp_excp_o),
        .disp_excp_num_o        (disp_excp_num_o)
    );

endmodule

//--- verilog/dispatch_reg.sv
`timescale 1ns/1ps

module dispatch_reg (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    dispatch_if.disp_mp                       disp,
    output logic                              disp_valid_o,
    output logic [31:0]                       disp_pc_o,
    output logic [31:0]                       disp_instr_o,
    output decode_pkg::aluop_e                disp_aluop_o,
    output decode_pkg::alusel_e               disp_alusel_o,
    output logic [1:0]                        disp_reg_read_valid_o,
    output logic [1:0][4:0]                   disp_reg_read_addr_o,
    output logic                              disp_reg_write_valid_o,
    output logic [4:0]                        disp_reg_write_addr_o,
    output logic [31:0]                       disp_imm_o,
    output logic                              disp_use_imm_o,
    output logic                              disp_refetch_o,
    output logic                              disp_excp_o,
    output logic [decode_pkg::EXCP_W-1:0]     disp_excp_num_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp_valid_o <= 1'b0;
            disp_excp_o  <= 1'b0;
        end else if (flush_i) begin
            disp_valid_o <= 1'b0;
            disp_excp_o  <= 1'b0;
        end else if (!stall_i) begin
            disp_valid_o <= disp.valid;
            disp_excp_o  <= disp.excp;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            disp_pc_o              <= disp.pc;
            disp_instr_o           <= disp.instr;
            disp_aluop_o           <= disp.aluop;
            disp_alusel_o          <= disp.alusel;
            disp_reg_read_valid_o  <= disp.reg_read_valid;
            disp_reg_read_addr_o   <= disp.reg_read_addr;
            disp_reg_write_valid_o <= disp.reg_write_valid;
            disp_reg_write_addr_o  <= disp.reg_write_addr;
            disp_imm_o             <= disp.imm;
            disp_use_imm_o         <= disp.use_imm;
            disp_refetch_o         <= disp.refetch;
            disp_excp_num_o        <= disp.excp_num;
        end
    end

    // Exceptions are only raised for valid slots upstream
    a_excp_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        disp_excp_o |-> disp_valid_o);

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !disp_valid_o);

endmodule

//--- verilog/instr_latch.sv
`timescale 1ns/1ps

module instr_latch (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    instr_valid_i,
    input  logic [31:0]             pc_i,
    input  logic [31:0]             instr_i,
    input  logic                    adef_i,
    output decode_pkg::instr_info_t instr_info_o
);

    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] instr_q;
    logic        adef_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_q    <= pc_i;
            instr_q <= instr_i;
            adef_q  <= adef_i;
        end
    end

    assign instr_info_o = '{valid_q, pc_q, instr_q, adef_q};

    // Slot must not move while dispatch is stalled
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> $stable(instr_info_o));

endmodule

//--- decoder/id.sv
`timescale 1ns/1ps

module id (
    input  decode_pkg::instr_info_t instr_info_i,
    input  logic                    has_int_i,
    input  logic [1:0]              csr_plv_i,
    dispatch_if.id_mp               disp
);
    import decode_pkg::*;

    sub_decode_t       res_3r;
    sub_decode_t       res_2ri12;
    sub_decode_t       res_i26;
    sub_decode_t       res_priv;
    sub_decode_t       merged;
    logic              kernel_op;
    logic              excp_ipe;
    logic              excp_ine;
    logic [EXCP_W-1:0] excp_num;

    decoder_3r u_decoder_3r (
        .instr_info_i (instr_info_i),
        .result_o     (res_3r)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_info_i (instr_info_i),
        .result_o     (res_2ri12)
    );

    decoder_i26 u_decoder_i26 (
        .instr_info_i (instr_info_i),
        .result_o     (res_i26)
    );

    decoder_priv u_decoder_priv (
        .instr_info_i (instr_info_i),
        .result_o     (res_priv)
    );

    // At most one sub-decoder hits
    assign merged = sub_decode_t'(res_3r | res_2ri12 | res_i26 | res_priv);

    assign kernel_op = merged.aluop inside {CSRRD, CSRWR, ERTN};
    assign excp_ipe  = instr_info_i.valid && kernel_op && (csr_plv_i == PLV_USER);
    assign excp_ine  = instr_info_i.valid && !merged.hit;

    assign excp_num = {excp_ipe, excp_ine, merged.is_break, merged.is_syscall,
                       instr_info_i.valid & instr_info_i.adef,
                       instr_info_i.valid & has_int_i};

    assign disp.valid           = instr_info_i.valid;
    assign disp.pc              = instr_info_i.pc;
    assign disp.instr           = instr_info_i.instr;
    assign disp.aluop           = merged.aluop;
    assign disp.alusel          = merged.alusel;
    assign disp.reg_read_valid  = merged.reg_read_valid;
    assign disp.reg_read_addr   = merged.reg_read_addr;
    assign disp.reg_write_valid = merged.reg_write_valid;
    assign disp.reg_write_addr  = merged.reg_write_addr;
    assign disp.imm             = merged.imm;
    assign disp.use_imm         = merged.use_imm;
    // ertn changes privilege state, later fetches must restart
    assign disp.refetch         = (merged.aluop == ERTN);
    assign disp.excp            = |excp_num;
    assign disp.excp_num        = excp_num;

endmodule

//--- decoder/decoder_priv.sv
`timescale 1ns/1ps

module decoder_priv (
    input  decode_pkg::instr_info_t instr_info_i,
    output decode_pkg::sub_decode_t result_o
);
    import decode_pkg::*;

    logic [31:0] instr;
    logic        is_csr;
    aluop_e      op;

    assign instr  = instr_info_i.instr;
    assign is_csr = (instr[31:24] == 8'h04);

    // rj selects the csr flavour
    always_comb begin
        op = NOP;
        if (instr == 32'h0648_3800) begin
            op = ERTN;
        end else if (is_csr && instr[9:5] == 5'd0) begin
            op = CSRRD;
        end else if (is_csr && instr[9:5] == 5'd1) begin
            op = CSRWR;
        end
    end

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != NOP) begin
            result_o.hit    = 1'b1;
            result_o.aluop  = op;
            result_o.alusel = CSR;
            if (op != ERTN) begin
                result_o.imm             = {18'b0, instr[23:10]};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = instr[4:0];
            end
            if (op == CSRWR) begin
                result_o.reg_read_valid[0] = 1'b1;
                result_o.reg_read_addr[0]  = instr[4:0];
            end
        end
    end

endmodule

//--- decoder/decoder_i26.sv
`timescale 1ns/1ps

module decoder_i26 (
    input  decode_pkg::instr_info_t instr_info_i,
    output decode_pkg::sub_decode_t result_o
);
    import decode_pkg::*;

    logic [31:0] instr;
    aluop_e      op;

    assign instr = instr_info_i.instr;

    always_comb begin
        case (instr[31:26])
            6'h14:   op = B;
            6'h15:   op = BL;
            default: op = NOP;
        endcase
    end

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != NOP) begin
            result_o.hit    = 1'b1;
            result_o.aluop  = op;
            result_o.alusel = BRANCH;
            // offs26 is split, high part sits in [9:0]
            result_o.imm    = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00};
            if (op == BL) begin
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = REG_RA;
            end
        end
    end

endmodule

//--- decoder/decoder_2ri12.sv
`timescale 1ns/1ps

module decoder_2ri12 (
    input  decode_pkg::instr_info_t instr_info_i,
    output decode_pkg::sub_decode_t result_o
);
    import decode_pkg::*;

    logic [31:0] instr;
    aluop_e      op;

    assign instr = instr_info_i.instr;

    always_comb begin
        case (instr[31:22])
            10'h008: op = SLTI;
            10'h00a: op = ADDI;
            10'h00d: op = ANDI;
            10'h00e: op = ORI;
            10'h0a2: op = LD_W;
            10'h0a6: op = ST_W;
            default: op = NOP;
        endcase
    end

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != NOP) begin
            result_o.hit               = 1'b1;
            result_o.aluop             = op;
            result_o.use_imm           = 1'b1;
            result_o.reg_read_valid[0] = 1'b1;
            result_o.reg_read_addr[0]  = instr[9:5];
            // Logic ops zero-extend
            if (op == ANDI || op == ORI) begin
                result_o.alusel = LOGIC;
                result_o.imm    = {20'b0, instr[21:10]};
            end else begin
                result_o.alusel = (op == LD_W || op == ST_W) ? MEM : ARITH;
                result_o.imm    = {{20{instr[21]}}, instr[21:10]};
            end
            // Store data comes from rd
            if (op == ST_W) begin
                result_o.reg_read_valid[1] = 1'b1;
                result_o.reg_read_addr[1]  = instr[4:0];
            end else begin
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = instr[4:0];
            end
        end
    end

endmodule

//--- decoder/decoder_3r.sv
`timescale 1ns/1ps

module decoder_3r (
    input  decode_pkg::instr_info_t instr_info_i,
    output decode_pkg::sub_decode_t result_o
);
    import decode_pkg::*;

    logic [31:0] instr;
    aluop_e      op;

    assign instr = instr_info_i.instr;

    always_comb begin
        case (instr[31:15])
            17'h00020: op = ADD;
            17'h00022: op = SUB;
            17'h00024: op = SLT;
            17'h00029: op = AND;
            17'h0002a: op = OR;
            17'h0002b: op = XOR;
            17'h00054: op = BREAK;
            17'h00056: op = SYSCALL;
            default:   op = NOP;
        endcase
    end

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != NOP) begin
            result_o.hit        = 1'b1;
            result_o.aluop      = op;
            result_o.is_break   = (op == BREAK);
            result_o.is_syscall = (op == SYSCALL);
            // break and syscall touch no registers
            if (op != BREAK && op != SYSCALL) begin
                result_o.alusel           = (op inside {AND, OR, XOR}) ? LOGIC : ARITH;
                result_o.reg_read_valid   = 2'b11;
                result_o.reg_read_addr[0] = instr[9:5];
                result_o.reg_read_addr[1] = instr[14:10];
                result_o.reg_write_valid  = 1'b1;
                result_o.reg_write_addr   = instr[4:0];
            end
        end
    end

endmodule

//--- common/dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if;
    import decode_pkg::*;

    logic              valid;
    logic [31:0]       pc;
    logic [31:0]       instr;
    aluop_e            aluop;
    alusel_e           alusel;
    logic [1:0]        reg_read_valid;
    // Index 0 is the first read port
    logic [1:0][4:0]   reg_read_addr;
    logic              reg_write_valid;
    logic [4:0]        reg_write_addr;
    logic [31:0]       imm;
    logic              use_imm;
    logic              refetch;
    logic              excp;
    logic [EXCP_W-1:0] excp_num;

    modport id_mp (
        output valid, pc, instr, aluop, alusel, reg_read_valid, reg_read_addr,
               reg_write_valid, reg_write_addr, imm, use_imm, refetch, excp, excp_num
    );

    modport disp_mp (
        input valid, pc, instr, aluop, alusel, reg_read_valid, reg_read_addr,
              reg_write_valid, reg_write_addr, imm, use_imm, refetch, excp, excp_num
    );

endinterface

//--- common/decode_pkg.sv
package decode_pkg;

    // Exception vector is {ipe, ine, break, syscall, adef, int}
    localparam int EXCP_W = 6;

    // Privileged ops fault at this level
    localparam logic [1:0] PLV_USER = 2'd3;

    // Link register for bl
    localparam logic [4:0] REG_RA = 5'd1;

    typedef enum logic [4:0] {
        NOP = 5'd0,
        ADD, SUB, SLT, AND, OR, XOR,
        ADDI, SLTI, ANDI, ORI,
        LD_W, ST_W,
        B, BL,
        CSRRD, CSRWR, ERTN,
        BREAK, SYSCALL
    } aluop_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        ARITH, LOGIC, MEM, BRANCH, CSR
    } alusel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        adef;
    } instr_info_t;

    // All zeros when the format does not match, so results merge by OR
    typedef struct packed {
        logic            hit;
        aluop_e          aluop;
        alusel_e         alusel;
        logic [1:0]      reg_read_valid;
        logic [1:0][4:0] reg_read_addr;
        logic            reg_write_valid;
        logic [4:0]      reg_write_addr;
        logic [31:0]     imm;
        logic            use_imm;
        logic            is_break;
        logic            is_syscall;
    } sub_decode_t;

endpackage
